/* bench/rv_core_testdata.hex */
// Word 0 is the program length N and word 1 the expected retire count M
// The next N words are the program, loaded at byte address 0
// Each of the M records holds pc, then rd_we in bit 8 with rd in bits 4:0, then wdata
00000032 00000026
FFB00093 12300113 0000A193 FFF13213 0F014293 40416313 7F00F393 00411413
0040D493 4010D513 002085B3 40110633 004116B3 0020A733 0020B7B3 00514833
0040D8B3 4040D933 007169B3 00237A33 ABCDEAB7 00001B17 00208463 00109463
00210463 00100B93 0020C463 00100B93 0020E463 0020F463 00100B93 00115463
00100B93 00209463 00100B93 00C00C6F 00100B93 00100B93 0A800C93 005C8D67
00100B93 00100B93 00100B93 0080006F 00100B93 00200DB3 00508013 0FF0000F
00000073 00100B93
// Register-immediate operations
00000000 00000101 FFFFFFFB  00000004 00000102 00000123
00000008 00000103 00000001  0000000C 00000104 00000001
00000010 00000105 000001D3  00000014 00000106 00000527
00000018 00000107 000007F0  0000001C 00000108 00001230
00000020 00000109 0FFFFFFF  00000024 0000010A FFFFFFFD
// Register-register operations
00000028 0000010B 0000011E  0000002C 0000010C 00000128
00000030 0000010D 00000246  00000034 0000010E 00000001
00000038 0000010F 00000000  0000003C 00000110 000000F0
00000040 00000111 7FFFFFFD  00000044 00000112 FFFFFFFD
00000048 00000113 000007F3  0000004C 00000114 00000123
// LUI and AUIPC
00000050 00000115 ABCDE000  00000054 00000116 00001054
// Branches, taken ones skip the word after them
00000058 00000000 00000000  0000005C 00000000 00000000
00000060 00000000 00000000  00000068 00000000 00000000
00000070 00000000 00000000  00000074 00000000 00000000
0000007C 00000000 00000000  00000084 00000000 00000000
// Jumps, x0 target, FENCE and ECALL
0000008C 00000118 00000090  00000098 00000119 000000A8
0000009C 0000011A 000000A0  000000AC 00000000 00000000
000000B4 0000011B 00000123  000000B8 00000000 00000000
000000BC 00000000 00000000  000000C0 00000000 00000000

/* bench/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module tb_rv_core;
  import core_pkg::*;

  localparam int MEM_WORDS = 1024;

  logic                     clk;
  logic                     rst;
  logic [`RV_XLEN-1:0]      imem_addr;
  rv_isa_pkg::insn_fields_t imem_data;
  retire_t                  retire;
  logic                     halt;

  logic [31:0] tdata [MEM_WORDS]; // Counts, program, then expected records
  int          n_prog;
  int          n_ret;
  int          limit;
  int          cycles;
  int          retired;

  rv_core_top DUT (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .retire    (retire),
    .halt      (halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      fail_run($sformatf("Mismatch on retire number %0d", retired));
    end
  endtask

  // Instruction memory with one cycle of read latency
  always @(posedge clk) begin
    int idx;
    idx = int'(imem_addr >> 2);
    if (idx < n_prog) begin
      imem_data <= rv_isa_pkg::insn_fields_t'(tdata[2 + idx]);
    end else begin
      imem_data <= '0; // Reads as an illegal word
    end
  end

  // Compare each retire against the next expected record
  always @(posedge clk) begin
    int base;
    if (!rst && retired == n_ret && halt !== 1'b1) begin
      fail_run("The core was not halted in the cycles after the final ECALL retired");
    end else if (!rst && retire.valid === 1'b1) begin
      if (retired >= n_ret) begin
        fail_run("An instruction retired after the expected end of the program");
      end else begin
        base = 2 + n_prog + 3 * retired;
        compare("retire.pc", retire.pc, tdata[base]);
        compare("retire.rd_we", {31'd0, retire.rd_we}, {31'd0, tdata[base + 1][8]});
        if (tdata[base + 1][8]) begin // rd and wdata only matter for a write
          compare("retire.rd", {27'd0, retire.rd}, {27'd0, tdata[base + 1][4:0]});
          compare("retire.wdata", retire.wdata, tdata[base + 2]);
        end
        retired <= retired + 1;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    if (cycles >= limit) begin
      fail_run($sformatf("Timeout, the core did not halt within %0d cycles", limit));
    end else begin
      cycles <= cycles + 1;
    end
  end

  initial begin
    rst       = 1'b1;
    imem_data = '0;
    cycles    = 0;
    retired   = 0;
    $readmemh("bench/rv_core_testdata.hex", tdata);
    n_prog = int'(tdata[0]);
    n_ret  = int'(tdata[1]);
    limit  = 2 * n_ret + n_prog + 20;

    if (n_prog <= 0 || n_ret <= 0 || 2 + n_prog + 3 * n_ret > MEM_WORDS) begin
      fail_run("The test data file is missing, empty or too large");
    end else begin
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      while (halt !== 1'b1) begin
        @(posedge clk);
      end
      repeat (4) @(posedge clk); // Nothing may retire once halted

      if (retired == n_ret) begin
        $display("Result: PASSED");
        $finish;
      end else begin
        fail_run($sformatf("Core halted after %0d of %0d expected retires", retired, n_ret));
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module alu (
  input  core_pkg::alu_op_e   op,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  output logic [`RV_XLEN-1:0] result
);
  import core_pkg::*;

  logic [`RV_SHAMT_W-1:0] shamt;
  logic                   lt_signed;
  logic                   lt_unsigned;

  assign shamt       = b[`RV_SHAMT_W-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt; // Sign fill
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none
`include "rv_defines.svh"

package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Where the register write-back value comes from
  typedef enum logic [1:0] {
    WB_ALU,
    WB_UIMM,    // LUI
    WB_PC_UIMM, // AUIPC
    WB_LINK     // JAL and JALR return address
  } wb_sel_e;

  typedef struct packed {
    alu_op_e                alu_op;
    logic                   b_imm;     // ALU operand b from the immediate
    wb_sel_e                wb_sel;
    logic                   rf_we;
    logic                   is_branch;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_ecall;
    rv_isa_pkg::branch_f3_e branch_cond;
    logic                   illegal;
    logic [4:0]             rd;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
  } ctrl_t;

  // Word now arriving from instruction memory
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
  } fetch_slot_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic                rd_we; // Only for a real write to a nonzero rd
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] wdata;
  } retire_t;

endpackage

`default_nettype wire

/* hdl/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module exec_unit (
  input  core_pkg::fetch_slot_t slot,
  input  core_pkg::ctrl_t       ctrl,
  input  logic [`RV_XLEN-1:0]   imm,
  input  logic [`RV_XLEN-1:0]   rs1_data,
  input  logic [`RV_XLEN-1:0]   rs2_data,
  output logic                  rf_we,
  output logic [`RV_XLEN-1:0]   rf_wdata,
  output logic                  redirect,
  output logic [`RV_XLEN-1:0]   redirect_pc,
  output logic                  ecall,
  output core_pkg::retire_t     retire
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_plus_imm;
  logic [`RV_XLEN-1:0] wb_value;
  logic                taken;
  logic                act;

  assign alu_b = ctrl.b_imm ? imm : rs2_data;

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  always_comb begin
    case (ctrl.branch_cond)
      BR_EQ:   taken = (rs1_data == rs2_data);
      BR_NE:   taken = (rs1_data != rs2_data);
      BR_LT:   taken = $signed(rs1_data) < $signed(rs2_data);
      BR_GE:   taken = $signed(rs1_data) >= $signed(rs2_data);
      BR_LTU:  taken = rs1_data < rs2_data;
      BR_GEU:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4    = slot.pc + `RV_XLEN'd4;
  assign pc_plus_imm = slot.pc + imm; // Branch, JAL and AUIPC

  always_comb begin
    case (ctrl.wb_sel)
      WB_ALU:     wb_value = alu_result;
      WB_UIMM:    wb_value = imm;
      WB_PC_UIMM: wb_value = pc_plus_imm;
      default:    wb_value = pc_plus4;
    endcase
  end

  // Nothing takes effect for a bubble or an illegal word
  assign act = slot.valid && !ctrl.illegal;

  assign rf_we    = act && ctrl.rf_we && (ctrl.rd != 5'd0);
  assign rf_wdata = wb_value;
  assign redirect = act && ((ctrl.is_branch && taken) || ctrl.is_jal || ctrl.is_jalr);
  assign ecall    = act && ctrl.is_ecall;

  assign redirect_pc = ctrl.is_jalr ? {alu_result[`RV_XLEN-1:1], 1'b0} : pc_plus_imm;

  always_comb begin
    retire.valid = slot.valid; // Illegal words still retire
    retire.pc    = slot.pc;
    retire.rd_we = rf_we;
    retire.rd    = ctrl.rd;
    retire.wdata = rf_we ? wb_value : '0;
  end

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  redirect,
  input  logic [`RV_XLEN-1:0]   redirect_pc,
  input  logic                  ecall,
  output logic [`RV_XLEN-1:0]   imem_addr,
  output core_pkg::fetch_slot_t slot,
  output logic                  halt
);

  logic [`RV_XLEN-1:0] pc;
  logic                halted;
  logic                freeze;

  // Stop advancing once ECALL is seen, and for good after that
  assign freeze = halted || ecall;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= `RV_RESET_PC;
      halted <= 1'b0;
    end else begin
      if (ecall) begin
        halted <= 1'b1;
      end
      if (!freeze) begin
        pc <= redirect ? redirect_pc : pc + `RV_XLEN'd4;
      end
    end
  end

  // The word fetched from pc comes back next cycle and carries pc as its tag
  always_ff @(posedge clk) begin
    if (rst) begin
      slot.valid <= 1'b0;
    end else begin
      slot.valid <= !(redirect || freeze); // Wrong-path or post-halt word
    end
    slot.pc <= pc;
  end

  assign imem_addr = pc;
  assign halt      = halted;

endmodule

`default_nettype wire

/* hdl/insn_decoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module insn_decoder (
  input  rv_isa_pkg::insn_fields_t insn,
  output core_pkg::ctrl_t          ctrl,
  output logic [`RV_XLEN-1:0]      imm
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic [31:0]         raw;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;
  logic                is_op;
  logic                is_shift;
  logic                alt;   // funct7 of SUB and SRA
  logic                f7_ok;
  alu_op_e             arith_op;

  assign raw = insn;

  assign imm_i = {{(`RV_XLEN-12){raw[31]}}, raw[31:20]};
  assign imm_b = {{(`RV_XLEN-13){raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
  assign imm_u = {raw[31:12], 12'b0};

  assign is_op    = (insn.opcode == OPC_OP);
  assign is_shift = (insn.funct3 == F3_SLL) || (insn.funct3 == F3_SR);
  assign alt      = (insn.funct7 == 7'b0100000);

  // Alternate encoding only exists for SUB, SRA and SRAI
  assign f7_ok = (insn.funct7 == 7'd0) ||
                 (alt && ((insn.funct3 == F3_SR) || (is_op && insn.funct3 == F3_ADD)));

  always_comb begin
    case (alu_f3_e'(insn.funct3))
      F3_ADD:  arith_op = (is_op && alt) ? ALU_SUB : ALU_ADD; // ADDI never subtracts
      F3_SLL:  arith_op = ALU_SLL;
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      F3_SR:   arith_op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   arith_op = ALU_OR;
      F3_AND:  arith_op = ALU_AND;
      default: arith_op = ALU_ADD;
    endcase
  end

  always_comb begin
    ctrl             = '0;
    ctrl.alu_op      = ALU_ADD;
    ctrl.wb_sel      = WB_ALU;
    ctrl.branch_cond = branch_f3_e'(insn.funct3);
    ctrl.rd          = insn.rd;
    ctrl.rs1         = insn.rs1;
    ctrl.rs2         = insn.rs2;
    imm              = imm_i;

    case (insn.opcode)
      OPC_LUI: begin
        ctrl.rf_we  = 1'b1;
        ctrl.wb_sel = WB_UIMM;
        imm         = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.rf_we  = 1'b1;
        ctrl.wb_sel = WB_PC_UIMM;
        imm         = imm_u;
      end
      OPC_JAL: begin
        ctrl.rf_we  = 1'b1;
        ctrl.wb_sel = WB_LINK;
        ctrl.is_jal = 1'b1;
        imm         = imm_j;
      end
      OPC_JALR: begin
        ctrl.rf_we   = 1'b1;
        ctrl.wb_sel  = WB_LINK;
        ctrl.is_jalr = 1'b1;
        ctrl.b_imm   = 1'b1; // Target is rs1 + imm through the ALU
        ctrl.illegal = (insn.funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.illegal   = (insn.funct3 == 3'b010) || (insn.funct3 == 3'b011);
        imm            = imm_b;
      end
      OPC_OP_IMM: begin
        ctrl.rf_we   = 1'b1;
        ctrl.b_imm   = 1'b1;
        ctrl.alu_op  = arith_op;
        ctrl.illegal = is_shift && !f7_ok; // Upper imm bits are free for the rest
      end
      OPC_OP: begin
        ctrl.rf_we   = 1'b1;
        ctrl.alu_op  = arith_op;
        ctrl.illegal = !f7_ok;
      end
      OPC_MISC_MEM: ctrl.illegal = (insn.funct3 != 3'b000); // FENCE does nothing here
      OPC_SYSTEM: begin
        ctrl.is_ecall = (raw[31:7] == 25'd0);
        ctrl.illegal  = (raw[31:7] != 25'd0);
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  input  logic [4:0]          rd,
  input  logic                we,
  input  logic [`RV_XLEN-1:0] wdata,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin // x0 stays zero
      regs[rd] <= wdata;
    end
  end

  // Combinational reads with no bypass of a write in flight
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_core_top (
  input  logic                     clk,
  input  logic                     rst,
  output logic [`RV_XLEN-1:0]      imem_addr,
  input  rv_isa_pkg::insn_fields_t imem_data,
  output core_pkg::retire_t        retire,
  output logic                     halt
);
  import core_pkg::*;

  fetch_slot_t         slot;
  ctrl_t               ctrl;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic                rf_we;
  logic [`RV_XLEN-1:0] rf_wdata;
  logic                redirect;
  logic [`RV_XLEN-1:0] redirect_pc;
  logic                ecall;

  fetch_unit u_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ecall       (ecall),
    .imem_addr   (imem_addr),
    .slot        (slot),
    .halt        (halt)
  );

  // Decode straight off the memory read data
  insn_decoder u_decode (
    .insn (imem_data),
    .ctrl (ctrl),
    .imm  (imm)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rd       (ctrl.rd),
    .we       (rf_we),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit u_exec (
    .slot        (slot),
    .ctrl        (ctrl),
    .imm         (imm),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .rf_we       (rf_we),
    .rf_wdata    (rf_wdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ecall       (ecall),
    .retire      (retire)
  );

endmodule

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // Conditional branch funct3 codes without the reserved 010 and 011
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_f3_e;

  typedef enum logic [2:0] {
    F3_ADD  = 3'b000, // ADD and SUB share this one
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101, // SRL or SRA by funct7
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

  // R-type view of one instruction word with the MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } insn_fields_t;

endpackage

`default_nettype wire

/* include/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Register and address width
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Shift amount field width for RV32
`define RV_SHAMT_W 5

`endif

/* run_sim.sh */
#!/bin/sh
# Build the RV32I core testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary -f rv_core.f --top-module tb_rv_core \
  --Mdir obj_dir -o tb_rv_core

./obj_dir/tb_rv_core | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* rv_core.f */
+incdir+include
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/insn_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/rv_core_top.sv
bench/tb_rv_core.sv
